/* filelist.f */
com_pkg.sv
crc_engine.sv
tx_buffer.sv
com_tx.sv
com_tx_top.sv
com_tx_properties.sv
com_tx_checker.sv
tb_com_tx.sv

/* run.sh */
#!/bin/sh
# build and run the com_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_com_tx -f filelist.f \
    -Mdir obj_dir -o sim_com_tx > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_com_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

/* tb_com_tx.sv */
`timescale 1ns/1ns

module tb_com_tx;

    import com_pkg::*;

    localparam int TIMEOUT = 1000;

    logic       clk;
    logic       rst;
    logic       fs;
    frame_req_t req;
    buf_wr_t    wr;
    logic       fd;
    line_byte_t line;
    int         seed;
    int         timeouts;

    com_tx_top DUT (
        .clk  (clk),
        .rst  (rst),
        .fs   (fs),
        .req  (req),
        .wr   (wr),
        .fd   (fd),
        .line (line)
    );

    com_tx_checker u_chk (
        .clk  (clk),
        .rst  (rst),
        .fs   (fs),
        .req  (req),
        .wr   (wr),
        .fd   (fd),
        .line (line)
    );

    bind com_tx com_tx_properties u_props (
        .clk     (clk),
        .rst     (rst),
        .fs      (fs),
        .req     (req),
        .fd      (fd),
        .line    (line),
        .rd_addr (rd_addr),
        .state   (state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge clk);
        wr <= '{en: 1'b1, addr: a, data: d};
        @(posedge clk);
        wr.en <= 1'b0;
    endtask

    // fs held until fd, then dropped until fd falls
    task automatic send_frame(input btype_t bt, input int dl, input int a);
        int n;
        @(posedge clk);
        req <= '{btype: bt, dlen: ADDR_W'(dl), addr: ADDR_W'(a)};
        fs  <= 1'b1;
        @(posedge clk);
        n = 0;
        while (!fd && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!fd) begin
            $display("timeout at %0t: fd did not rise for frame type %0h", $time, bt);
            timeouts++;
        end
        fs <= 1'b0;
        @(posedge clk);
        n = 0;
        while (fd && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (fd) begin
            $display("timeout at %0t: fd did not fall after fs dropped", $time);
            timeouts++;
        end
    endtask

    initial begin
        btype_t bt;
        int     dl;
        int     a;
        int     total;
        rst      = 1'b1;
        fs       = 1'b0;
        req      = '0;
        wr       = '0;
        seed     = 89525;
        timeouts = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);

        for (int i = 0; i < RAM_DEPTH; i++) begin
            write_byte(ADDR_W'(i), 8'((i * 37) ^ (i >> 7)));
        end

        send_frame(BAG_ACK, 0, 0);
        send_frame(BAG_NAK, 0, 0);
        send_frame(BAG_STL, 0, 0);

        // status frames, including the address wrap at the top
        send_frame(BAG_DLINK, 1, 4095);
        send_frame(BAG_DTYPE, 5, 4093);
        send_frame(BAG_DTEMP, 1 + ({$random(seed)} % 64), {$random(seed)} % RAM_DEPTH);

        for (int i = 0; i < 10; i++) begin
            bt = ({$random(seed)} % 2 == 0) ? BAG_DATA0 : BAG_DATA1;
            dl = 1 + ({$random(seed)} % 64);
            a  = {$random(seed)} % RAM_DEPTH;
            send_frame(bt, dl, a);
        end

        // fresh buffer contents between frames
        for (int i = 0; i < 4; i++) begin
            a = {$random(seed)} % RAM_DEPTH;
            write_byte(ADDR_W'(a), 8'($random(seed)));
            write_byte(ADDR_W'(a + 1), 8'($random(seed)));
            send_frame((i % 2 == 0) ? BAG_DTEMP : BAG_DATA1, 2, a);
        end

        send_frame(btype_t'(4'h5), 3, 0);
        repeat (5) @(posedge clk);

        total = u_chk.errors + timeouts;
        $display("errors: %0d checker, %0d timeout, %0d total over %0d frames",
                 u_chk.errors, timeouts, total, u_chk.frames);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* com_tx_checker.sv */
`timescale 1ns/1ns

module com_tx_checker (
    input logic                clk,
    input logic                rst,
    input logic                fs,
    input com_pkg::frame_req_t req,
    input com_pkg::buf_wr_t    wr,
    input logic                fd,
    input com_pkg::line_byte_t line
);

    import com_pkg::*;

    typedef logic [7:0] byte_q_t[$];

    logic [7:0] shadow [RAM_DEPTH];
    byte_q_t    exp_q;
    int         idx;
    logic       active;
    logic       fs_q;
    logic       fd_q;
    int         errors = 0;
    int         frames = 0;

    // lsb first, right shift with reflected poly, inverted result
    function automatic logic [15:0] ref_crc(input int w, input logic [15:0] poly,
                                            input logic [15:0] init, input byte_q_t data);
        logic [15:0] rpoly;
        logic [15:0] mask;
        logic [15:0] r;
        logic        fb;
        rpoly = '0;
        for (int i = 0; i < w; i++) begin
            rpoly[i] = poly[w-1-i];
        end
        mask = 16'((32'd1 << w) - 1);
        r = init;
        foreach (data[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ data[k][b];
                r = r >> 1;
                if (fb) begin
                    r = r ^ rpoly;
                end
            end
        end
        return ~r & mask;
    endfunction

    function automatic byte_q_t build_frame(input frame_req_t r);
        byte_q_t     q;
        byte_q_t     pay;
        logic [7:0]  pid;
        logic [15:0] c;
        q = {};
        case (r.btype)
            BAG_ACK:                         pid = PID_ACK;
            BAG_NAK:                         pid = PID_NAK;
            BAG_STL:                         pid = PID_STL;
            BAG_DLINK, BAG_DTYPE, BAG_DTEMP: pid = PID_STAT;
            BAG_DATA0:                       pid = PID_DATA0;
            BAG_DATA1:                       pid = PID_DATA1;
            default:                         return q;
        endcase
        for (int i = 0; i < PLEN; i++) begin
            q.push_back(PID_PREM);
        end
        q.push_back(PID_SYNC);
        q.push_back(pid);
        if (r.btype inside {BAG_ACK, BAG_NAK, BAG_STL}) begin
            return q;
        end
        q.push_back({4'h0, r.dlen[11:8]});
        q.push_back(r.dlen[7:0]);
        for (int i = 0; i < r.dlen; i++) begin
            pay.push_back(shadow[ADDR_W'(r.addr + i)]);
            q.push_back(shadow[ADDR_W'(r.addr + i)]);
        end
        if (r.btype inside {BAG_DLINK, BAG_DTYPE, BAG_DTEMP}) begin
            c = ref_crc(5, 16'(CRC5_POLY), 16'(CRC5_INIT), pay);
            q.push_back(c[7:0]);
        end else begin
            c = ref_crc(16, CRC16_POLY, CRC16_INIT, pay);
            q.push_back(c[15:8]);
            q.push_back(c[7:0]);
        end
        return q;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            active = 1'b0;
            fs_q   = 1'b0;
            fd_q   = 1'b0;
            idx    = 0;
        end else begin
            if (wr.en) begin
                shadow[wr.addr] = wr.data;
            end
            if (line.en) begin
                if (!active || idx >= exp_q.size()) begin
                    $display("unexpected line byte %02h at %0t outside any frame", line.data,
                             $time);
                    errors++;
                end else begin
                    if (line.data !== exp_q[idx]) begin
                        $display("mismatch at %0t: byte %0d expected %02h seen %02h", $time,
                                 idx, exp_q[idx], line.data);
                        errors++;
                    end
                    idx++;
                end
            end
            if (fd && !fd_q) begin
                if (!active) begin
                    $display("fd rose at %0t without a frame request", $time);
                    errors++;
                end else if (idx != exp_q.size()) begin
                    $display("mismatch at %0t: frame length expected %0d seen %0d", $time,
                             exp_q.size(), idx);
                    errors++;
                end
                active = 1'b0;
                frames++;
            end
            if (fs && !fs_q && !fd) begin
                exp_q  = build_frame(req);
                idx    = 0;
                active = 1'b1;
            end
            fs_q = fs;
            fd_q = fd;
        end
    end

endmodule

/* com_tx_properties.sv */
`timescale 1ns/1ns

module com_tx_properties (
    input logic                       clk,
    input logic                       rst,
    input logic                       fs,
    input com_pkg::frame_req_t        req,
    input logic                       fd,
    input com_pkg::line_byte_t        line,
    input logic [com_pkg::ADDR_W-1:0] rd_addr,
    input com_pkg::state_t            state
);

    import com_pkg::*;

    a_quiet_idle: assert property (@(posedge clk) disable iff (rst)
        (state == WAIT || state == DONE) |-> !line.en)
        else $error("line.en high while the framer is in WAIT or DONE");

    a_fd_not_with_byte: assert property (@(posedge clk) disable iff (rst)
        !(fd && line.en))
        else $error("fd high together with a line byte");

    // payload addressing walks the buffer one byte per cycle
    a_rd_addr_step: assert property (@(posedge clk) disable iff (rst)
        (state == WORK) |=> (rd_addr == $past(rd_addr) + 1'b1))
        else $error("rd_addr did not step by one during WORK");

    a_dlen_nonzero: assert property (@(posedge clk) disable iff (rst)
        (state == WAIT && fs &&
         req.btype inside {BAG_DLINK, BAG_DTYPE, BAG_DTEMP, BAG_DATA0, BAG_DATA1})
        |-> (req.dlen != '0))
        else $error("data-bearing frame started with zero length");

endmodule

/* com_tx_top.sv */
`timescale 1ns/1ns

module com_tx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                fs,
    input  com_pkg::frame_req_t req,
    input  com_pkg::buf_wr_t    wr,
    output logic                fd,
    output com_pkg::line_byte_t line
);

    import com_pkg::*;

    logic [ADDR_W-1:0] rd_addr;
    logic [7:0]        rd_data;
    logic              crc_clear;
    logic              crc_en;
    logic [7:0]        crc_din;
    logic [4:0]        crc5_val;
    logic [15:0]       crc16_val;

    tx_buffer u_buf (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    com_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .req       (req),
        .fd        (fd),
        .line      (line),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_din   (crc_din),
        .crc5_val  (crc5_val),
        .crc16_val (crc16_val)
    );

    // both engines run on every payload frame, framer picks one
    crc_engine #(
        .crc_t (logic [4:0]),
        .POLY  (CRC5_POLY),
        .INIT  (CRC5_INIT)
    ) u_crc5 (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .din   (crc_din),
        .crc   (crc5_val)
    );

    crc_engine #(
        .crc_t (logic [15:0]),
        .POLY  (CRC16_POLY),
        .INIT  (CRC16_INIT)
    ) u_crc16 (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .din   (crc_din),
        .crc   (crc16_val)
    );

endmodule

/* com_tx.sv */
`timescale 1ns/1ns

module com_tx (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fs,
    input  com_pkg::frame_req_t        req,
    output logic                       fd,
    output com_pkg::line_byte_t        line,
    output logic [com_pkg::ADDR_W-1:0] rd_addr,
    input  logic [7:0]                 rd_data,
    output logic                       crc_clear,
    output logic                       crc_en,
    output logic [7:0]                 crc_din,
    input  logic [4:0]                 crc5_val,
    input  logic [15:0]                crc16_val
);

    import com_pkg::*;

    state_t            state;
    state_t            next_state;
    logic [ADDR_W-1:0] num;
    logic [ADDR_W-1:0] cnt_end;
    logic              cnt_done;
    logic [7:0]        pid;
    stage_t            stg;
    stage_t            stg_d;

    logic              hshake;
    logic              status;
    logic              dframe;
    logic              known;

    always_comb begin
        hshake = 1'b0;
        status = 1'b0;
        dframe = 1'b0;
        case (req.btype)
            BAG_ACK, BAG_NAK, BAG_STL:       hshake = 1'b1;
            BAG_DLINK, BAG_DTYPE, BAG_DTEMP: status = 1'b1;
            BAG_DATA0, BAG_DATA1:            dframe = 1'b1;
            default: ;
        endcase
    end

    assign known = hshake | status | dframe;

    // last count value of the current state
    always_comb begin
        case (state)
            PREM:    cnt_end = ADDR_W'(PLEN - 1);
            DNUM:    cnt_end = ADDR_W'(NLEN - 1);
            WORK:    cnt_end = req.dlen - 1'b1;
            CRC16:   cnt_end = ADDR_W'(CLEN - 1);
            GAP:     cnt_end = ADDR_W'(GLEN - 1);
            default: cnt_end = '0;
        endcase
    end

    assign cnt_done = (num == cnt_end);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                // unknown type skips straight to fd
                if (fs) begin
                    next_state = known ? PREM : DONE;
                end
            end
            PREM: begin
                if (cnt_done) begin
                    next_state = SYNC;
                end
            end
            SYNC: next_state = WPID;
            WPID: next_state = hshake ? GAP : DNUM;
            DNUM: begin
                if (cnt_done) begin
                    next_state = WORK;
                end
            end
            WORK: begin
                if (cnt_done) begin
                    next_state = status ? CRC5 : CRC16;
                end
            end
            CRC5: next_state = GAP;
            CRC16: begin
                if (cnt_done) begin
                    next_state = GAP;
                end
            end
            GAP: begin
                if (cnt_done) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                if (!fs) begin
                    next_state = WAIT;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // shared byte counter, restarts on every state change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= '0;
        end else if (next_state != state) begin
            num <= '0;
        end else if (state inside {PREM, DNUM, WORK, CRC16, GAP}) begin
            num <= num + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pid <= 8'h00;
        end else if (state == SYNC) begin
            case (req.btype)
                BAG_ACK:                         pid <= PID_ACK;
                BAG_NAK:                         pid <= PID_NAK;
                BAG_STL:                         pid <= PID_STL;
                BAG_DLINK, BAG_DTYPE, BAG_DTEMP: pid <= PID_STAT;
                BAG_DATA0:                       pid <= PID_DATA0;
                BAG_DATA1:                       pid <= PID_DATA1;
                default:                         pid <= 8'h00;
            endcase
        end
    end

    // the two length cycles cover the read latency,
    // so the first payload byte lands in the first WORK cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (state == WPID) begin
            rd_addr <= req.addr;
        end else if (state == DNUM || state == WORK) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    always_comb begin
        stg_d = '0;
        case (state)
            PREM: begin
                stg_d.en   = 1'b1;
                stg_d.data = PID_PREM;
            end
            SYNC: begin
                stg_d.en   = 1'b1;
                stg_d.data = PID_SYNC;
            end
            WPID: begin
                stg_d.en   = 1'b1;
                stg_d.data = pid;
            end
            DNUM: begin
                stg_d.en   = 1'b1;
                stg_d.data = (num == '0) ? {4'h0, req.dlen[11:8]} : req.dlen[7:0];
            end
            WORK: begin
                stg_d.en   = 1'b1;
                stg_d.pay  = 1'b1;
                stg_d.data = rd_data;
            end
            CRC5: begin
                stg_d.en  = 1'b1;
                stg_d.sel = SEL_CRC5;
            end
            CRC16: begin
                stg_d.en  = 1'b1;
                stg_d.sel = (num == '0) ? SEL_CRC_HI : SEL_CRC_LO;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stg <= '0;
        end else begin
            stg <= stg_d;
        end
    end

    // crc slots pick up the engine value here, one cycle after the last payload byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line <= '0;
        end else begin
            line.en <= stg.en;
            case (stg.sel)
                SEL_CRC5:   line.data <= {3'b000, crc5_val};
                SEL_CRC_HI: line.data <= crc16_val[15:8];
                SEL_CRC_LO: line.data <= crc16_val[7:0];
                default:    line.data <= stg.data;
            endcase
        end
    end

    assign crc_clear = (state == SYNC);
    assign crc_en    = stg.pay;
    assign crc_din   = stg.data;
    assign fd        = (state == DONE);

endmodule

/* tx_buffer.sv */
`timescale 1ns/1ns

module tx_buffer (
    input  logic                       clk,
    input  com_pkg::buf_wr_t           wr,
    input  logic [com_pkg::ADDR_W-1:0] rd_addr,
    output logic [7:0]                 rd_data
);

    import com_pkg::*;

    logic [7:0] mem [RAM_DEPTH];
    logic [7:0] rd_pipe [RAM_LATENCY];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // array read plus extra stages up to RAM_LATENCY
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < RAM_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rd_data = rd_pipe[RAM_LATENCY-1];

endmodule

/* crc_engine.sv */
`timescale 1ns/1ns

module crc_engine #(
    parameter type  crc_t = logic [15:0],
    parameter crc_t POLY  = '0,
    parameter crc_t INIT  = '1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       en,
    input  logic [7:0] din,
    output crc_t       crc
);

    localparam int W = $bits(crc_t);

    function automatic crc_t reflect(crc_t p);
        crc_t r;
        for (int i = 0; i < W; i++) begin
            r[i] = p[W-1-i];
        end
        return r;
    endfunction

    localparam crc_t RPOLY = reflect(POLY);

    // one byte, lsb first, right shifting register
    function automatic crc_t fold(crc_t r, logic [7:0] d);
        crc_t c;
        c = r;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ RPOLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    crc_t acc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= INIT;
        end else if (clear) begin
            acc <= INIT;
        end else if (en) begin
            acc <= fold(acc, din);
        end
    end

    assign crc = ~acc;

endmodule

/* com_pkg.sv */
package com_pkg;

    // buffer geometry
    localparam int ADDR_W      = 12;
    localparam int RAM_DEPTH   = 1 << ADDR_W;
    localparam int RAM_LATENCY = 2;

    // field lengths in bytes
    localparam int PLEN = 4;
    localparam int NLEN = 2;
    localparam int CLEN = 2;
    // cycles spent in GAP before fd
    localparam int GLEN = 4;

    localparam logic [7:0] PID_PREM  = 8'h5A;
    localparam logic [7:0] PID_SYNC  = 8'h0F;
    localparam logic [7:0] PID_ACK   = 8'h2D;
    localparam logic [7:0] PID_NAK   = 8'hA5;
    localparam logic [7:0] PID_STL   = 8'hE1;
    localparam logic [7:0] PID_STAT  = 8'hD2;
    localparam logic [7:0] PID_DATA0 = 8'h96;
    localparam logic [7:0] PID_DATA1 = 8'h5A;

    // polynomials in normal form, engines reflect them
    localparam logic [4:0]  CRC5_POLY  = 5'h05;
    localparam logic [4:0]  CRC5_INIT  = 5'h1F;
    localparam logic [15:0] CRC16_POLY = 16'h8005;
    localparam logic [15:0] CRC16_INIT = 16'hFFFF;

    typedef enum logic [3:0] {
        BAG_ACK   = 4'b0001,
        BAG_NAK   = 4'b0010,
        BAG_STL   = 4'b0011,
        BAG_DLINK = 4'b1000,
        BAG_DTYPE = 4'b1001,
        BAG_DTEMP = 4'b1010,
        BAG_DATA0 = 4'b1101,
        BAG_DATA1 = 4'b1110
    } btype_t;

    typedef enum logic [3:0] {
        IDLE, WAIT, PREM, SYNC, WPID, DNUM, WORK, CRC5, CRC16, GAP, DONE
    } state_t;

    // what the output register puts on the line for a stage byte
    typedef enum logic [1:0] {
        SEL_BYTE, SEL_CRC5, SEL_CRC_HI, SEL_CRC_LO
    } sel_t;

    typedef struct packed {
        btype_t            btype;
        logic [ADDR_W-1:0] dlen;
        logic [ADDR_W-1:0] addr;
    } frame_req_t;

    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
    } buf_wr_t;

    typedef struct packed {
        logic       en;
        logic [7:0] data;
    } line_byte_t;

    typedef struct packed {
        logic       en;
        logic       pay;
        sel_t       sel;
        logic [7:0] data;
    } stage_t;

endpackage
